/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bus_host_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/bus_bench_pkg.sv */
// Bus bench package with bus widths, register count and the sequencer state encoding
package bus_bench_pkg;

    // Bus word width, shared by master_data, slave_data and the slave registers
    localparam int data_width = 32;

    // Slave register file
    localparam int reg_count = 4;
    localparam int sel_width = 2;    // Enough to address reg_count entries

    // Trigger LFSR, only its low data_width bits leave the block
    localparam int lfsr_width = 128;

    // Bus sequencer, fixed five-step walk per transaction
    typedef enum logic [2:0] {
        bus_idle      = 3'd0,    // Waiting for master_req
        bus_arbitrate = 3'd1,    // Timed wait, single master only
        bus_transfer  = 3'd2,    // Register write
        bus_output    = 3'd3,    // Read back and ack
        bus_complete  = 3'd4     // Ack drops, back to idle
    } bus_state_t;

endpackage

/* design/bus_host_regs.sv */
// Bus host sequencer with a four-entry slave register file and read-back ack
`timescale 1ns/100ps

module bus_host_regs #(
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT0 = '0,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT1 = '0,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT2 = '0,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT3 = '0
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 master_req,
    input  logic [bus_bench_pkg::sel_width-1:0]  reg_sel,
    input  logic [bus_bench_pkg::data_width-1:0] write_data,
    output logic [bus_bench_pkg::data_width-1:0] slave_data,
    output logic                                 bus_ack
);

    import bus_bench_pkg::*;

    bus_state_t state;
    bus_state_t state_next;

    logic [data_width-1:0] slave_regs [reg_count];

    // Fixed walk, only idle waits on the master
    always_comb begin
        state_next = state;
        case (state)
            bus_idle: begin
                if (master_req) begin
                    state_next = bus_arbitrate;
                end
            end
            bus_arbitrate: state_next = bus_transfer;    // Single master, plain delay
            bus_transfer:  state_next = bus_output;
            bus_output:    state_next = bus_complete;
            bus_complete:  state_next = bus_idle;
            default:       state_next = bus_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= bus_idle;
        end else begin
            state <= state_next;
        end
    end

    // Register file, one write per transaction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slave_regs[0] <= REG_INIT0;
            slave_regs[1] <= REG_INIT1;
            slave_regs[2] <= REG_INIT2;
            slave_regs[3] <= REG_INIT3;
        end else if (state == bus_transfer) begin
            slave_regs[reg_sel] <= write_data;    // reg_sel held by the master
        end
    end

    // Read back the entry just written, one edge after the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slave_data <= '0;
            bus_ack    <= 1'b0;
        end else begin
            bus_ack <= (state == bus_output);    // High for the complete state only
            if (state == bus_output) begin
                slave_data <= slave_regs[reg_sel];
            end
        end
    end

    // Ack is a single-cycle pulse
    a_ack_pulse: assert property (
        @(posedge clk) disable iff (rst)
        bus_ack |=> !bus_ack
    ) else $error("bus_ack held high for more than one cycle");

    // Request seen in idle gives the ack four cycles later, and not before
    a_ack_latency: assert property (
        @(posedge clk) disable iff (rst)
        (state == bus_idle && master_req) |-> !bus_ack [*4] ##1 bus_ack
    ) else $error("bus_ack did not follow the request after four cycles");

    // Write in transfer must be visible at the next read-back
    a_readback: assert property (
        @(posedge clk) disable iff (rst)
        (state == bus_transfer) |=> ##1 (slave_data == $past(write_data, 2))
    ) else $error("Read-back word differs from the written word");

endmodule

/* design/bus_host_top.sv */
// Bus host top level with the request LFSR, payload block and host sequencer
`timescale 1ns/100ps

module bus_host_top #(
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT0     = 32'h89ABCDEF,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT1     = 32'h09844DFE,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT2     = 32'h89ABCDEF,
    parameter logic [bus_bench_pkg::data_width-1:0] REG_INIT3     = 32'h856EE81F,
    parameter logic [bus_bench_pkg::lfsr_width-1:0] LFSR_INIT     =
        128'h0123456789ABCDEF0123456789ABCDEF,
    parameter logic [bus_bench_pkg::data_width-1:0] TRIGGER_MASK  = 32'h0000000F,
    parameter logic [bus_bench_pkg::data_width-1:0] TRIGGER_VALUE = 32'h00000005,
    parameter logic [bus_bench_pkg::data_width-1:0] PAYLOAD_XOR   = 32'h0000FFFF
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [bus_bench_pkg::data_width-1:0] master_data,
    input  logic                                 master_req,
    input  logic [bus_bench_pkg::sel_width-1:0]  reg_sel,
    output logic [bus_bench_pkg::data_width-1:0] slave_data,
    output logic                                 bus_ack
);

    import bus_bench_pkg::*;

    logic [data_width-1:0] lfsr_word;     // Trigger source
    logic [data_width-1:0] write_data;    // Possibly corrupted master word

    req_lfsr #(
        .LFSR_INIT (LFSR_INIT)
    ) u_lfsr (
        .clk        (clk),
        .rst        (rst),
        .master_req (master_req),
        .lfsr_word  (lfsr_word)
    );

    // Sits in the write path between master and register file
    trojan_payload #(
        .TRIGGER_MASK  (TRIGGER_MASK),
        .TRIGGER_VALUE (TRIGGER_VALUE),
        .PAYLOAD_XOR   (PAYLOAD_XOR)
    ) u_payload (
        .lfsr_word   (lfsr_word),
        .master_data (master_data),
        .write_data  (write_data)
    );

    bus_host_regs #(
        .REG_INIT0 (REG_INIT0),
        .REG_INIT1 (REG_INIT1),
        .REG_INIT2 (REG_INIT2),
        .REG_INIT3 (REG_INIT3)
    ) u_host (
        .clk        (clk),
        .rst        (rst),
        .master_req (master_req),
        .reg_sel    (reg_sel),
        .write_data (write_data),
        .slave_data (slave_data),
        .bus_ack    (bus_ack)
    );

endmodule

/* design/req_lfsr.sv */
// Request-stepped 128-bit Fibonacci LFSR that feeds the trigger compare
`timescale 1ns/100ps

module req_lfsr #(
    parameter logic [bus_bench_pkg::lfsr_width-1:0] LFSR_INIT = '1
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 master_req,
    output logic [bus_bench_pkg::data_width-1:0] lfsr_word
);

    import bus_bench_pkg::*;

    logic [lfsr_width-1:0] lfsr_state;
    logic                  feedback;

    // Taps 127, 6, 1, 0
    assign feedback = lfsr_state[lfsr_width-1] ^ lfsr_state[6] ^ lfsr_state[1] ^ lfsr_state[0];

    // Steps in every sequencer state, as long as the request is up
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_state <= LFSR_INIT;
        end else if (master_req) begin
            lfsr_state <= {lfsr_state[lfsr_width-2:0], feedback};
        end
    end

    assign lfsr_word = lfsr_state[data_width-1:0];    // Low word only

    // An all-zero state would lock up and freeze the trigger input for good
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        lfsr_state != '0
    ) else $error("LFSR state reached all zeros");

endmodule

/* design/trojan_payload.sv */
// Trigger compare on the LFSR word and payload XOR on the bus write data
`timescale 1ns/100ps

module trojan_payload #(
    parameter logic [bus_bench_pkg::data_width-1:0] TRIGGER_MASK  = '0,
    parameter logic [bus_bench_pkg::data_width-1:0] TRIGGER_VALUE = '1,
    parameter logic [bus_bench_pkg::data_width-1:0] PAYLOAD_XOR   = '0
) (
    input  logic [bus_bench_pkg::data_width-1:0] lfsr_word,
    input  logic [bus_bench_pkg::data_width-1:0] master_data,
    output logic [bus_bench_pkg::data_width-1:0] write_data
);

    logic trigger;

    // Only the masked bits of the LFSR word take part in the compare
    assign trigger = (lfsr_word & TRIGGER_MASK) == TRIGGER_VALUE;

    // No latency since the sequencer samples write_data at its transfer edge
    always_comb begin
        if (trigger) begin
            write_data = master_data ^ PAYLOAD_XOR;    // Corrupted word
        end else begin
            write_data = master_data;    // Clean pass-through
        end
    end

    // Any change to the word must stay inside the payload pattern
    always_comb begin
        assert final (((write_data ^ master_data) & ~PAYLOAD_XOR) == '0)
            else $error("Write data changed outside the payload bits");
    end

endmodule

/* flist.f */
design/bus_bench_pkg.sv
design/req_lfsr.sv
design/trojan_payload.sv
design/bus_host_regs.sv
design/bus_host_top.sv
verification/tb_clock_gen.sv
verification/bus_host_tb.sv

/* verification/bus_host_tb.sv */
// Bus host testbench with random transactions checked against a trigger and register model
`timescale 1ns/100ps

module bus_host_tb;

    import bus_bench_pkg::*;

    localparam logic [data_width-1:0] reg_init0     = 32'h89ABCDEF;
    localparam logic [data_width-1:0] reg_init1     = 32'h09844DFE;
    localparam logic [data_width-1:0] reg_init2     = 32'h89ABCDEF;
    localparam logic [data_width-1:0] reg_init3     = 32'h856EE81F;
    localparam logic [lfsr_width-1:0] lfsr_init     = 128'h0123456789ABCDEF0123456789ABCDEF;
    localparam logic [data_width-1:0] trigger_mask  = 32'h0000000F;
    localparam logic [data_width-1:0] trigger_value = 32'h00000005;
    localparam logic [data_width-1:0] payload_xor   = 32'h0000FFFF;

    localparam int num_trans      = 400;
    localparam int timeout_cycles = num_trans * 9 + 20;    // At most 8 cycles per transaction

    logic                  clk;
    logic                  rst;
    logic [data_width-1:0] master_data;
    logic                  master_req;
    logic [sel_width-1:0]  reg_sel;
    logic [data_width-1:0] slave_data;
    logic                  bus_ack;

    logic [15:0]           rand_state;
    logic [lfsr_width-1:0] model_lfsr;    // Copy of the trigger LFSR
    logic [data_width-1:0] model_regs [reg_count];
    logic [data_width-1:0] last_ack_data;    // Word slave_data must hold between acks
    int                    cycle_count = 0;
    int                    value_errors;
    int                    timing_errors;
    int                    other_errors;
    int                    trigger_hits;

    tb_clock_gen u_clock (
        .clk (clk),
        .rst (rst)
    );

    bus_host_top #(
        .REG_INIT0     (reg_init0),
        .REG_INIT1     (reg_init1),
        .REG_INIT2     (reg_init2),
        .REG_INIT3     (reg_init3),
        .LFSR_INIT     (lfsr_init),
        .TRIGGER_MASK  (trigger_mask),
        .TRIGGER_VALUE (trigger_value),
        .PAYLOAD_XOR   (payload_xor)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .master_data (master_data),
        .master_req  (master_req),
        .reg_sel     (reg_sel),
        .slave_data  (slave_data),
        .bus_ack     (bus_ack)
    );

    // Stimulus LFSR with taps 16 14 13 11
    function automatic logic [15:0] stim_lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Trigger LFSR rule that shifts left with taps 127 6 1 0
    function automatic logic [lfsr_width-1:0] trigger_lfsr_step(
        input logic [lfsr_width-1:0] s
    );
        return {s[lfsr_width-2:0], s[lfsr_width-1] ^ s[6] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            rand_state = stim_lfsr_step(rand_state);
            bits = {bits[30:0], rand_state[0]};
        end
    endtask

    function automatic logic [data_width-1:0] dut_reg(input int idx);
        case (idx)
            0:       return uut.u_host.slave_regs[0];
            1:       return uut.u_host.slave_regs[1];
            2:       return uut.u_host.slave_regs[2];
            default: return uut.u_host.slave_regs[3];
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    // Unselected entries must still match the model
    task automatic check_reg_file();
        string name;
        for (int i = 0; i < reg_count; i++) begin
            name = $sformatf("slave_regs[%0d]", i);
            compare_word(name, dut_reg(i), model_regs[i]);
        end
    endtask

    task automatic run_transaction();
        logic [31:0]           bits;
        logic [data_width-1:0] data;
        logic [sel_width-1:0]  sel;
        logic [data_width-1:0] expected;
        logic                  trig;
        int                    edges;
        int                    gap;

        take_bits(32, bits);
        data = bits;
        take_bits(2, bits);
        sel = bits[1:0];
        take_bits(2, bits);
        gap = int'(bits[1:0]);    // Idle cycles after the ack
        trig = 1'b0;
        edges = 0;

        master_data = data;
        reg_sel     = sel;
        master_req  = 1'b1;

        // Request held until ack, so the model LFSR steps on every edge
        do begin
            @(posedge clk);
            if (edges == 2) begin
                // Transfer edge
                trig = (model_lfsr[data_width-1:0] & trigger_mask) == trigger_value;
            end
            model_lfsr = trigger_lfsr_step(model_lfsr);
            edges++;
            #1;
            if (!bus_ack) begin
                compare_word("slave_data", slave_data, last_ack_data);
            end
        end while (!bus_ack);

        assert (edges == 4) else begin
            $display("bus_ack came %0d cycles after the request instead of 4", edges);
            timing_errors++;
        end

        expected = trig ? (data ^ payload_xor) : data;
        if (trig) begin
            trigger_hits++;
        end
        model_regs[sel] = expected;
        last_ack_data   = expected;
        compare_word("slave_data", slave_data, expected);
        check_reg_file();
        master_req = 1'b0;

        // One-cycle pulse
        @(posedge clk);
        #1;
        compare_word("bus_ack", 32'(bus_ack), 32'd0);
        compare_word("slave_data", slave_data, last_ack_data);

        repeat (gap) begin
            @(posedge clk);
            #1;
            compare_word("bus_ack", 32'(bus_ack), 32'd0);
            compare_word("slave_data", slave_data, last_ack_data);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout, the test was still running after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        master_data   = '0;
        master_req    = 1'b0;
        reg_sel       = '0;
        rand_state    = 16'd91;
        model_lfsr    = lfsr_init;
        model_regs[0] = reg_init0;
        model_regs[1] = reg_init1;
        model_regs[2] = reg_init2;
        model_regs[3] = reg_init3;
        last_ack_data = '0;
        value_errors  = 0;
        timing_errors = 0;
        other_errors  = 0;
        trigger_hits  = 0;

        @(negedge rst);
        compare_word("bus_ack", 32'(bus_ack), 32'd0);
        compare_word("slave_data", slave_data, 32'd0);
        check_reg_file();    // Initial register values

        for (int t = 0; t < num_trans; t++) begin
            run_transaction();
        end

        assert (trigger_hits > 0) else begin
            $display("No transaction met the trigger, so no payload write was checked");
            other_errors++;
        end

        $display("Errors: %0d value, %0d timing, %0d other, %0d of %0d transactions triggered",
                 value_errors, timing_errors, other_errors, trigger_hits, num_trans);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and reset source, 100 ns clock with reset held for the first cycles
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int half_period  = 50,    // ns
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;    // Released just after an edge, like the stimulus
    end

endmodule
